// File: common/packet_pkg.sv
package packet_pkg;

    // Narrow input word is one 4-byte word, wide output word packs four of them
    localparam int DATA_IN_BYTES = 4;
    localparam int CONVERT_RATIO = 4;
    localparam int DATA_OUT_BYTES = DATA_IN_BYTES * CONVERT_RATIO;
    localparam int META_WID = 8;

    localparam int MTY_IN_WID = $clog2(DATA_IN_BYTES);
    localparam int MTY_OUT_WID = $clog2(DATA_OUT_BYTES);

    // Byte 0 sits at the most significant end (network byte order)
    typedef logic [0:DATA_IN_BYTES-1][7:0] narrow_data_t;
    typedef logic [0:DATA_OUT_BYTES-1][7:0] wide_data_t;
    typedef logic [MTY_IN_WID-1:0] narrow_mty_t;
    typedef logic [MTY_OUT_WID-1:0] wide_mty_t;

    typedef struct packed {
        narrow_data_t          data;
        logic                  eop;
        narrow_mty_t           mty;
        logic                  err;
        logic [META_WID-1:0]   meta;
    } narrow_word_t;

    typedef struct packed {
        wide_data_t            data;
        logic                  eop;
        wide_mty_t             mty;
        logic                  err;
        logic [META_WID-1:0]   meta;
    } wide_word_t;

    typedef enum logic {
        DISPATCH_SOP,
        DISPATCH_BODY
    } dispatch_state_t;

    typedef enum logic {
        MERGE_SOP,
        MERGE_BODY
    } merge_state_t;

endpackage

// File: source/packet_dispatch.sv
`timescale 1ns/1ns

module packet_dispatch #(
    parameter int NUM_LANES = 4
) (
    input  logic                                     from_tx,
    input  logic                                     srst,
    input  logic                                     in_vld,
    input  packet_pkg::narrow_word_t                 in_word,
    output logic                                     in_rdy,
    output logic [NUM_LANES-1:0]                     lane_in_vld,
    output packet_pkg::narrow_word_t [NUM_LANES-1:0] lane_in_word,
    input  logic [NUM_LANES-1:0]                     lane_in_rdy
);

    localparam int PTR_WID = $clog2(NUM_LANES);

    typedef logic [PTR_WID-1:0] ptr_t;

    ptr_t                        lane_ptr;
    packet_pkg::dispatch_state_t state;
    logic                        in_fire;
    logic                        eop_fire;

    // Only the current lane sees a valid word, the data is shared by all
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            lane_in_vld[k] = in_vld && (lane_ptr == ptr_t'(k));
            lane_in_word[k] = in_word;
        end
    end

    assign in_rdy = lane_in_rdy[lane_ptr];
    assign in_fire = in_vld && in_rdy;
    assign eop_fire = in_fire && in_word.eop;

    // Track where we are inside the packet
    always_ff @(posedge from_tx) begin
        if (srst) begin
            state <= packet_pkg::DISPATCH_SOP;
        end else begin
            case (state)
                packet_pkg::DISPATCH_SOP: begin
                    if (in_fire && !in_word.eop) begin
                        state <= packet_pkg::DISPATCH_BODY;
                    end
                end
                packet_pkg::DISPATCH_BODY: begin
                    if (eop_fire) begin
                        state <= packet_pkg::DISPATCH_SOP;
                    end
                end
                default: begin
                    state <= packet_pkg::DISPATCH_SOP;
                end
            endcase
        end
    end

    // Move on to the next lane once the whole packet has gone out
    always_ff @(posedge from_tx) begin
        if (srst) begin
            lane_ptr <= '0;
        end else if (eop_fire) begin
            if (lane_ptr == ptr_t'(NUM_LANES - 1)) begin
                lane_ptr <= '0;
            end else begin
                lane_ptr <= lane_ptr + 1'b1;
            end
        end
    end

endmodule

// File: packet_width_converter/packet_width_converter.sv
`timescale 1ns/1ns

module packet_width_converter #(
    parameter bit LATCH_META_ON_SOP = 1'b1
) (
    input  logic                     from_tx,
    input  logic                     srst,
    input  logic                     in_vld,
    input  packet_pkg::narrow_word_t in_word,
    output logic                     in_rdy,
    output logic                     out_vld,
    output packet_pkg::wide_word_t   out_word,
    input  logic                     out_rdy
);

    localparam int RATIO = packet_pkg::CONVERT_RATIO;
    localparam int IN_BYTES = packet_pkg::DATA_IN_BYTES;
    localparam int OUT_BYTES = packet_pkg::DATA_OUT_BYTES;

    typedef logic [$clog2(RATIO+1)-1:0] pack_cnt_t;

    pack_cnt_t                              pack_cnt;
    packet_pkg::narrow_data_t [0:RATIO-1]   slots;
    packet_pkg::narrow_mty_t                last_mty;
    logic                                   last_eop;
    logic                                   err_acc;
    logic [packet_pkg::META_WID-1:0]        meta_q;
    logic                                   sop;
    logic                                   in_fire;
    logic                                   out_fire;
    logic                                   word_start;

    // The completed word is ready once all slots are filled or the packet ended
    assign out_vld = (pack_cnt == pack_cnt_t'(RATIO)) || ((pack_cnt != '0) && last_eop);
    assign in_rdy = out_rdy || !out_vld;

    assign in_fire = in_vld && in_rdy;
    assign out_fire = out_vld && out_rdy;

    // An accepted word opens a new wide word if nothing is held or the held one leaves now
    assign word_start = (pack_cnt == '0) || out_fire;

    always_ff @(posedge from_tx) begin
        if (srst) begin
            pack_cnt <= '0;
        end else if (in_fire && word_start) begin
            pack_cnt <= pack_cnt_t'(1);
        end else if (in_fire) begin
            pack_cnt <= pack_cnt + 1'b1;
        end else if (out_fire) begin
            pack_cnt <= '0;
        end
    end

    // Fill from the most significant slot, clearing the rest on a fresh word
    always_ff @(posedge from_tx) begin
        if (in_fire) begin
            if (word_start) begin
                slots <= '0;
                slots[0] <= in_word.data;
            end else begin
                slots[pack_cnt] <= in_word.data;
            end
        end
    end

    always_ff @(posedge from_tx) begin
        if (srst) begin
            last_eop <= 1'b0;
        end else if (in_fire) begin
            last_eop <= in_word.eop;
        end
    end

    always_ff @(posedge from_tx) begin
        if (in_fire) begin
            last_mty <= in_word.mty;
        end
    end

    // Error is sticky across the narrow words of one wide word
    always_ff @(posedge from_tx) begin
        if (in_fire) begin
            if (word_start) begin
                err_acc <= in_word.err;
            end else begin
                err_acc <= err_acc | in_word.err;
            end
        end
    end

    always_ff @(posedge from_tx) begin
        if (in_fire && (!LATCH_META_ON_SOP || sop)) begin
            meta_q <= in_word.meta;
        end
    end

    // Next accepted word starts a packet when the previous one ended
    always_ff @(posedge from_tx) begin
        if (srst) begin
            sop <= 1'b1;
        end else if (in_fire) begin
            sop <= in_word.eop;
        end
    end

    assign out_word.data = slots;
    assign out_word.eop = last_eop;
    assign out_word.mty = packet_pkg::wide_mty_t'(OUT_BYTES - int'(pack_cnt) * IN_BYTES
                                                  + int'(last_mty));
    assign out_word.err = err_acc;
    assign out_word.meta = meta_q;

endmodule

// File: source/packet_merge.sv
`timescale 1ns/1ns

module packet_merge #(
    parameter int NUM_LANES = 4
) (
    input  logic                                   from_tx,
    input  logic                                   srst,
    input  logic [NUM_LANES-1:0]                   lane_out_vld,
    input  packet_pkg::wide_word_t [NUM_LANES-1:0] lane_out_word,
    output logic [NUM_LANES-1:0]                   lane_out_rdy,
    output logic                                   out_vld,
    output packet_pkg::wide_word_t                 out_word,
    input  logic                                   out_rdy
);

    localparam int PTR_WID = $clog2(NUM_LANES);

    typedef logic [PTR_WID-1:0] ptr_t;

    ptr_t                     lane_ptr;
    packet_pkg::merge_state_t state;
    logic                     out_fire;
    logic                     eop_fire;

    // Only the lane whose turn it is may hand over a word
    assign out_vld = lane_out_vld[lane_ptr];
    assign out_word = lane_out_word[lane_ptr];

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            lane_out_rdy[k] = out_rdy && (lane_ptr == ptr_t'(k));
        end
    end

    assign out_fire = out_vld && out_rdy;
    assign eop_fire = out_fire && out_word.eop;

    always_ff @(posedge from_tx) begin
        if (srst) begin
            state <= packet_pkg::MERGE_SOP;
        end else begin
            case (state)
                packet_pkg::MERGE_SOP: begin
                    if (out_fire && !out_word.eop) begin
                        state <= packet_pkg::MERGE_BODY;
                    end
                end
                packet_pkg::MERGE_BODY: begin
                    if (eop_fire) begin
                        state <= packet_pkg::MERGE_SOP;
                    end
                end
                default: begin
                    state <= packet_pkg::MERGE_SOP;
                end
            endcase
        end
    end

    // Same round-robin order as the dispatcher keeps packets in sequence
    always_ff @(posedge from_tx) begin
        if (srst) begin
            lane_ptr <= '0;
        end else if (eop_fire) begin
            if (lane_ptr == ptr_t'(NUM_LANES - 1)) begin
                lane_ptr <= '0;
            end else begin
                lane_ptr <= lane_ptr + 1'b1;
            end
        end
    end

endmodule

// File: source/packet_lanes_top.sv
`timescale 1ns/1ns

module packet_lanes_top #(
    parameter int NUM_LANES = 4,
    parameter bit LATCH_META_ON_SOP = 1'b1
) (
    input  logic                     from_tx,
    input  logic                     srst,
    input  logic                     in_vld,
    input  packet_pkg::narrow_word_t in_word,
    output logic                     in_rdy,
    output logic                     out_vld,
    output packet_pkg::wide_word_t   out_word,
    input  logic                     out_rdy
);

    logic [NUM_LANES-1:0]                     lane_in_vld;
    packet_pkg::narrow_word_t [NUM_LANES-1:0] lane_in_word;
    logic [NUM_LANES-1:0]                     lane_in_rdy;

    logic [NUM_LANES-1:0]                     lane_out_vld;
    packet_pkg::wide_word_t [NUM_LANES-1:0]   lane_out_word;
    logic [NUM_LANES-1:0]                     lane_out_rdy;

    packet_dispatch #(
        .NUM_LANES (NUM_LANES)
    ) packet_dispatch_inst (
        .from_tx      (from_tx),
        .srst         (srst),
        .in_vld       (in_vld),
        .in_word      (in_word),
        .in_rdy       (in_rdy),
        .lane_in_vld  (lane_in_vld),
        .lane_in_word (lane_in_word),
        .lane_in_rdy  (lane_in_rdy)
    );

    // One single-word upsizer per lane
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        packet_width_converter #(
            .LATCH_META_ON_SOP (LATCH_META_ON_SOP)
        ) packet_width_converter_inst (
            .from_tx  (from_tx),
            .srst     (srst),
            .in_vld   (lane_in_vld[k]),
            .in_word  (lane_in_word[k]),
            .in_rdy   (lane_in_rdy[k]),
            .out_vld  (lane_out_vld[k]),
            .out_word (lane_out_word[k]),
            .out_rdy  (lane_out_rdy[k])
        );
    end

    packet_merge #(
        .NUM_LANES (NUM_LANES)
    ) packet_merge_inst (
        .from_tx       (from_tx),
        .srst          (srst),
        .lane_out_vld  (lane_out_vld),
        .lane_out_word (lane_out_word),
        .lane_out_rdy  (lane_out_rdy),
        .out_vld       (out_vld),
        .out_word      (out_word),
        .out_rdy       (out_rdy)
    );

endmodule

// File: test/packet_lanes_tb.sv
`timescale 1ns/1ns

module packet_lanes_tb;

    localparam int NUM_LANES = 4;
    localparam int NUM_DIRECTED = 8;
    localparam int NUM_RAND_PKTS = 24;
    localparam int NUM_PKTS = NUM_DIRECTED + NUM_RAND_PKTS;
    localparam int CLK_PERIOD = 4;
    localparam int IN_BYTES = packet_pkg::DATA_IN_BYTES;
    localparam int OUT_BYTES = packet_pkg::DATA_OUT_BYTES;
    localparam int RATIO = packet_pkg::CONVERT_RATIO;

    logic                     from_tx;
    logic                     srst;
    logic                     in_vld;
    packet_pkg::narrow_word_t in_word;
    logic                     in_rdy;
    logic                     out_vld;
    packet_pkg::wide_word_t   out_word;
    logic                     out_rdy;

    packet_pkg::wide_word_t   exp_q[$];
    packet_pkg::wide_word_t   exp_word;
    int                       data_errors;
    int                       proto_errors;
    int                       words_seen;
    bit                       rand_rdy;

    packet_lanes_top #(
        .NUM_LANES         (NUM_LANES),
        .LATCH_META_ON_SOP (1'b1)
    ) packet_lanes_top_inst (
        .from_tx  (from_tx),
        .srst     (srst),
        .in_vld   (in_vld),
        .in_word  (in_word),
        .in_rdy   (in_rdy),
        .out_vld  (out_vld),
        .out_word (out_word),
        .out_rdy  (out_rdy)
    );

    initial begin
        from_tx = 1'b0;
        forever #(CLK_PERIOD / 2) from_tx = ~from_tx;
    end

    // Builds one packet, queues its expected wide words and drives its narrow words
    task automatic send_packet(input int len);
        packet_pkg::narrow_word_t words[$];
        packet_pkg::narrow_word_t nw;
        packet_pkg::wide_word_t   ww;
        logic [7:0]               meta0;
        int                       n_words;
        meta0 = 8'($urandom);
        n_words = (len + IN_BYTES - 1) / IN_BYTES;
        for (int i = 0; i < n_words; i++) begin
            nw = '0;
            for (int j = 0; j < IN_BYTES; j++) begin
                if (i * IN_BYTES + j < len) begin
                    nw.data[j] = 8'($urandom);
                end
            end
            nw.eop = (i == n_words - 1);
            nw.mty = nw.eop ? packet_pkg::narrow_mty_t'(n_words * IN_BYTES - len) : '0;
            nw.err = ($urandom_range(0, 5) == 0);
            nw.meta = meta0 + 8'(i);
            words.push_back(nw);
        end
        // Each wide word takes up to four narrow words, byte 0 at the top
        for (int w = 0; w * RATIO < n_words; w++) begin
            ww = '0;
            for (int s = 0; s < RATIO && w * RATIO + s < n_words; s++) begin
                nw = words[w * RATIO + s];
                for (int j = 0; j < IN_BYTES; j++) begin
                    ww.data[s * IN_BYTES + j] = nw.data[j];
                end
                ww.err = ww.err | nw.err;
                ww.eop = nw.eop;
            end
            // The last wide word is empty for whatever the packet bytes leave unused
            if (ww.eop) begin
                ww.mty = packet_pkg::wide_mty_t'(OUT_BYTES - (len - w * OUT_BYTES));
            end
            ww.meta = meta0;
            exp_q.push_back(ww);
        end
        for (int i = 0; i < n_words; i++) begin
            in_vld = 1'b1;
            in_word = words[i];
            do @(posedge from_tx); while (!in_rdy);
            #1;
        end
        in_vld = 1'b0;
    endtask

    // Sink readiness changes just after the edge, like the other inputs
    always @(posedge from_tx) begin
        #1;
        if (rand_rdy) begin
            out_rdy = ($urandom_range(0, 3) != 0);
        end
    end

    always @(posedge from_tx) begin
        if (!srst && out_vld && out_rdy) begin
            if (exp_q.size() == 0) begin
                proto_errors++;
                $display("Output word at time %0t arrived with no packet pending", $time);
            end else begin
                exp_word = exp_q.pop_front();
                assert (out_word === exp_word) else begin
                    data_errors++;
                    $display("FAIL %0t ns: wide word %0d got %h expected %h",
                             $time, words_seen, out_word, exp_word);
                end
                words_seen++;
            end
        end
    end

    hold_check: assert property (@(posedge from_tx) disable iff (srst)
        out_vld && !out_rdy |=> out_vld && $stable(out_word))
        else begin
            proto_errors++;
            $display("Output word changed or was dropped while out_rdy was low at time %0t",
                     $time);
        end

    reset_check: assert property (@(posedge from_tx) $fell(srst) |-> !out_vld && in_rdy)
        else begin
            proto_errors++;
            $display("After reset out_vld was not low or in_rdy was not high at time %0t",
                     $time);
        end

    known_check: assert property (@(posedge from_tx) disable iff (srst) !$isunknown(out_vld))
        else begin
            proto_errors++;
            $display("out_vld is unknown at time %0t", $time);
        end

    initial begin
        void'($urandom(2));
        srst = 1'b1;
        in_vld = 1'b0;
        in_word = '0;
        out_rdy = 1'b1;
        rand_rdy = 1'b0;
        data_errors = 0;
        proto_errors = 0;
        words_seen = 0;
        repeat (10) @(posedge from_tx);
        #1;
        srst = 1'b0;
        // Full words, short and partial packets, back to back across all lanes twice
        send_packet(16);
        send_packet(32);
        send_packet(1);
        send_packet(7);
        send_packet(20);
        send_packet(40);
        send_packet(2);
        send_packet(35);
        rand_rdy = 1'b1;
        for (int i = 0; i < NUM_RAND_PKTS; i++) begin
            send_packet($urandom_range(1, 40));
        end
        while (exp_q.size() != 0) begin
            @(posedge from_tx);
        end
        repeat (5) @(posedge from_tx);
        $display("Errors: data %0d, protocol %0d, wide words checked %0d",
                 data_errors, proto_errors, words_seen);
        if (data_errors == 0 && proto_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #((NUM_PKTS * 200 + 20) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", NUM_PKTS * 200 + 20);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: packet_lanes.f
common/packet_pkg.sv
source/packet_dispatch.sv
packet_width_converter/packet_width_converter.sv
source/packet_merge.sv
source/packet_lanes_top.sv
test/packet_lanes_tb.sv
